// ==== rtl/icache_cfg_pkg.sv ====
/*
 * Instruction cache bypass configuration.
 * Sizes of the fetch and fill paths and the vector types built on them.
 */

`default_nettype none

package icache_cfg_pkg;

  // Port count and bus widths
  localparam int unsigned NR_FETCH_PORTS = 2;
  localparam int unsigned FETCH_AW       = 32;
  localparam int unsigned FETCH_DW       = 32;
  localparam int unsigned LINE_WIDTH     = 128;

  // Derived alignment of words within a line
  localparam int unsigned LINE_ALIGN     = $clog2(LINE_WIDTH / 8);
  localparam int unsigned FETCH_ALIGN    = $clog2(FETCH_DW / 8);
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;

  // One order FIFO slot per port, since each port has at most one fill in flight
  localparam int unsigned RSP_FIFO_DEPTH = NR_FETCH_PORTS;

  typedef logic [FETCH_AW-1:0]                 addr_t;
  typedef logic [FETCH_DW-1:0]                 fetch_word_t;
  typedef logic [LINE_WIDTH-1:0]               line_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel_t;
  typedef logic [NR_FETCH_PORTS-1:0]           port_mask_t;

endpackage

`default_nettype wire

// ==== rtl/icache_bus_pkg.sv ====
/*
 * Instruction cache bypass bus types.
 * Payloads of fill responses and of per-port fetch responses.
 */

`default_nettype none

package icache_bus_pkg;

  // A whole line returned by the fill channel
  typedef struct packed {
    icache_cfg_pkg::line_t       data;
    logic                        error;
  } fill_rsp_t;

  // The word handed back to one fetch port
  typedef struct packed {
    icache_cfg_pkg::fetch_word_t data;
    logic                        error;
  } fetch_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/bypass_port_ctrl.sv ====
/*
 * Bypass fetch port controller.
 * Requests the line holding the fetch address, captures its word
 * from the fill response and presents it for one cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module bypass_port_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  icache_cfg_pkg::addr_t      addr_i,
  output logic                       ready_o,
  output icache_bus_pkg::fetch_rsp_t rsp_o,
  output logic                       line_req_o,
  output icache_cfg_pkg::addr_t      line_addr_o,
  input  logic                       grant_i,
  input  logic                       rsp_strobe_i,
  input  icache_bus_pkg::fill_rsp_t  fill_rsp_i
);

  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } state_e;

  state_e                      state_d;
  state_e                      state_q;
  icache_cfg_pkg::addr_t       addr_q;
  icache_cfg_pkg::word_sel_t   word_sel;
  icache_cfg_pkg::fetch_word_t word;
  logic                        take_addr;
  logic                        capture;

  always_comb begin
    state_d    = state_q;
    take_addr  = 1'b0;
    capture    = 1'b0;
    line_req_o = 1'b0;
    ready_o    = 1'b0;
    unique case (state_q)
      Idle: begin
        if (valid_i) begin
          take_addr = 1'b1;
          state_d   = RequestData;
        end
      end
      // Hold the request until the arbiter hands the fill channel to this port
      RequestData: begin
        line_req_o = 1'b1;
        if (grant_i) state_d = WaitResponse;
      end
      WaitResponse: begin
        if (rsp_strobe_i) begin
          capture = 1'b1;
          state_d = PresentResponse;
        end
      end
      // The word is served from the response register for exactly one cycle
      PresentResponse: begin
        ready_o = 1'b1;
        state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Fill requests always cover a whole line
  assign line_addr_o = {addr_q[icache_cfg_pkg::FETCH_AW-1:icache_cfg_pkg::LINE_ALIGN],
                        {icache_cfg_pkg::LINE_ALIGN{1'b0}}};

  assign word_sel = addr_q[icache_cfg_pkg::LINE_ALIGN-1:icache_cfg_pkg::FETCH_ALIGN];
  assign word     = fill_rsp_i.data[word_sel*icache_cfg_pkg::FETCH_DW +: icache_cfg_pkg::FETCH_DW];

  always_ff @(posedge clk_i) begin
    if (take_addr) addr_q <= addr_i;
    if (capture) begin
      rsp_o.data  <= word;
      rsp_o.error <= fill_rsp_i.error;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fill_req_arbiter.sv ====
/*
 * Fill request arbiter.
 * Round-robin choice among requesting ports for the single fill channel.
 */

`timescale 1ns/1ps
`default_nettype none

module fill_req_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  icache_cfg_pkg::port_mask_t                             req_i,
  input  icache_cfg_pkg::addr_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] addr_i,
  output logic                                                   fill_req_valid_o,
  output icache_cfg_pkg::addr_t                                  fill_req_addr_o,
  input  logic                                                   fill_req_ready_i,
  output icache_cfg_pkg::port_mask_t                             grant_o
);

  icache_cfg_pkg::port_mask_t prio_q;
  icache_cfg_pkg::port_mask_t lock_sel_q;
  icache_cfg_pkg::port_mask_t masked_req;
  icache_cfg_pkg::port_mask_t cand;
  icache_cfg_pkg::port_mask_t sel;
  icache_cfg_pkg::port_mask_t sel_shift;
  logic                       lock_q;
  logic                       handshake;
  logic                       stall;

  // Ports at or above the pointer win first, otherwise wrap to the lowest requester
  always_comb begin
    masked_req = req_i & prio_q;
    cand       = (|masked_req) ? masked_req : req_i;
    sel        = lock_q ? lock_sel_q : (cand & (~cand + 1'b1));
    sel_shift  = sel << 1;
    fill_req_addr_o = '0;
    for (int i = 0; i < icache_cfg_pkg::NR_FETCH_PORTS; i++) begin
      if (sel[i]) fill_req_addr_o = fill_req_addr_o | addr_i[i];
    end
  end

  assign fill_req_valid_o = |req_i;
  assign handshake        = fill_req_valid_o & fill_req_ready_i;
  assign stall            = fill_req_valid_o & ~fill_req_ready_i;
  assign grant_o          = handshake ? sel : '0;

  // A stalled choice is kept so that the channel holds steady under back-pressure
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= '1;
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      lock_q <= stall;
      if (stall) lock_sel_q <= sel;
      if (handshake) prio_q <= ~(sel_shift - 1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fill_rsp_router.sv ====
/*
 * Fill response router.
 * Order FIFO of granted port masks that strobes the owner of each response.
 */

`timescale 1ns/1ps
`default_nettype none

module fill_rsp_router (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  icache_cfg_pkg::port_mask_t grant_i,
  input  logic                       fill_rsp_valid_i,
  output icache_cfg_pkg::port_mask_t rsp_strobe_o
);

  typedef logic [icache_cfg_pkg::RSP_FIFO_DEPTH-1:0] slot_mask_t;

  icache_cfg_pkg::port_mask_t mem_q [icache_cfg_pkg::RSP_FIFO_DEPTH];
  icache_cfg_pkg::port_mask_t head;
  slot_mask_t                 wr_ptr_q;
  slot_mask_t                 rd_ptr_q;
  slot_mask_t                 used_q;
  slot_mask_t                 used_d;
  logic                       head_used;
  logic                       push;
  logic                       pop;

  // Pointers are one-hot and rotate through the slots
  always_comb begin
    head      = '0;
    head_used = 1'b0;
    for (int i = 0; i < icache_cfg_pkg::RSP_FIFO_DEPTH; i++) begin
      if (rd_ptr_q[i]) begin
        head      = mem_q[i];
        head_used = used_q[i];
      end
    end
  end

  assign push = |grant_i;
  assign pop  = fill_rsp_valid_i & head_used;

  assign rsp_strobe_o = pop ? head : '0;

  // A slot freed and refilled in one cycle ends up occupied
  assign used_d = (used_q & ~(pop ? rd_ptr_q : '0)) | (push ? wr_ptr_q : '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= slot_mask_t'(1);
      rd_ptr_q <= slot_mask_t'(1);
      used_q   <= '0;
    end else begin
      used_q <= used_d;
      if (push) wr_ptr_q <= {wr_ptr_q[icache_cfg_pkg::RSP_FIFO_DEPTH-2:0],
                             wr_ptr_q[icache_cfg_pkg::RSP_FIFO_DEPTH-1]};
      if (pop) rd_ptr_q <= {rd_ptr_q[icache_cfg_pkg::RSP_FIFO_DEPTH-2:0],
                            rd_ptr_q[icache_cfg_pkg::RSP_FIFO_DEPTH-1]};
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < icache_cfg_pkg::RSP_FIFO_DEPTH; i++) begin
      if (push && wr_ptr_q[i]) mem_q[i] <= grant_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_bypass_top.sv ====
/*
 * Instruction cache bypass path.
 * Fetch ports share one fill channel through a round-robin arbiter,
 * and an order FIFO returns each in-order fill response to its owner.
 */

`timescale 1ns/1ps
`default_nettype none

module icache_bypass_top (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  input  icache_cfg_pkg::port_mask_t                                inst_valid_i,
  input  icache_cfg_pkg::addr_t      [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_addr_i,
  output icache_cfg_pkg::port_mask_t                                inst_ready_o,
  output icache_bus_pkg::fetch_rsp_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_rsp_o,
  output logic                                                      fill_req_valid_o,
  output icache_cfg_pkg::addr_t                                     fill_req_addr_o,
  input  logic                                                      fill_req_ready_i,
  input  logic                                                      fill_rsp_valid_i,
  input  icache_bus_pkg::fill_rsp_t                                 fill_rsp_i
);

  icache_cfg_pkg::port_mask_t                                line_req;
  icache_cfg_pkg::addr_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] line_addr;
  icache_cfg_pkg::port_mask_t                                grant;
  icache_cfg_pkg::port_mask_t                                rsp_strobe;

  // One controller per fetch port, all seeing the same fill response
  for (genvar i = 0; i < icache_cfg_pkg::NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_ctrl i_port_ctrl (
      .clk_i        ( clk_i           ),
      .arst_n_i     ( arst_n_i        ),
      .valid_i      ( inst_valid_i[i] ),
      .addr_i       ( inst_addr_i[i]  ),
      .ready_o      ( inst_ready_o[i] ),
      .rsp_o        ( inst_rsp_o[i]   ),
      .line_req_o   ( line_req[i]     ),
      .line_addr_o  ( line_addr[i]    ),
      .grant_i      ( grant[i]        ),
      .rsp_strobe_i ( rsp_strobe[i]   ),
      .fill_rsp_i   ( fill_rsp_i      )
    );
  end

  fill_req_arbiter i_req_arbiter (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .req_i            ( line_req         ),
    .addr_i           ( line_addr        ),
    .fill_req_valid_o ( fill_req_valid_o ),
    .fill_req_addr_o  ( fill_req_addr_o  ),
    .fill_req_ready_i ( fill_req_ready_i ),
    .grant_o          ( grant            )
  );

  // Responses come back in request order, so the grant sequence names the owner
  fill_rsp_router i_rsp_router (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .grant_i          ( grant            ),
    .fill_rsp_valid_i ( fill_rsp_valid_i ),
    .rsp_strobe_o     ( rsp_strobe       )
  );

endmodule

`default_nettype wire

// ==== dv/icache_bypass_assert.sv ====
/*
 * Port behaviour checks for the instruction cache bypass path.
 * Bound into the top level, covering fetch words, the fill channel and pulses.
 */

`timescale 1ns/1ps
`default_nettype none

module icache_bypass_assert (
  input logic                                                      clk_i,
  input logic                                                      arst_n_i,
  input icache_cfg_pkg::port_mask_t                                inst_valid_i,
  input icache_cfg_pkg::addr_t      [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_addr_i,
  input icache_cfg_pkg::port_mask_t                                inst_ready_o,
  input icache_bus_pkg::fetch_rsp_t [icache_cfg_pkg::NR_FETCH_PORTS-1:0] inst_rsp_o,
  input logic                                                      fill_req_valid_o,
  input icache_cfg_pkg::addr_t                                     fill_req_addr_o,
  input logic                                                      fill_req_ready_i,
  input icache_cfg_pkg::port_mask_t                                line_req_i,
  input icache_cfg_pkg::port_mask_t                                grant_i
);

  int unsigned                fail_cnt = 0;
  string                      fail_sig = "";
  logic [31:0]                fail_got = '0;
  logic [31:0]                fail_exp = '0;
  logic                       seen_valid_q;
  logic                       stall_q;
  logic                       prev_both_q;
  icache_cfg_pkg::port_mask_t prev_grant_q;
  icache_cfg_pkg::addr_t      addr_prev_q;

  // Word k of the line at A holds A + 4k with the upper half pattern applied
  function automatic icache_cfg_pkg::fetch_word_t word_at(icache_cfg_pkg::addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  task automatic note_failure(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (fail_cnt == 0) begin
      fail_sig = name;
      fail_got = got;
      fail_exp = exp;
    end
    fail_cnt++;
  endtask

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seen_valid_q <= 1'b0;
      stall_q      <= 1'b0;
      prev_both_q  <= 1'b0;
      prev_grant_q <= '0;
    end else begin
      seen_valid_q <= seen_valid_q | (|inst_valid_i);
      stall_q      <= fill_req_valid_o & ~fill_req_ready_i;
      if (|grant_i) begin
        prev_grant_q <= grant_i;
        prev_both_q  <= &line_req_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    addr_prev_q <= fill_req_addr_o;
  end

  for (genvar p = 0; p < icache_cfg_pkg::NR_FETCH_PORTS; p++) begin : gen_port_chk
    word_ok: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |-> inst_rsp_o[p].data == word_at(inst_addr_i[p]))
      else begin
        note_failure($sformatf("inst_rsp_o[%0d].data", p), $sampled(inst_rsp_o[p].data),
                     word_at($sampled(inst_addr_i[p])));
        $error("Fetch word mismatch on port %0d", p);
      end

    error_ok: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |-> inst_rsp_o[p].error == inst_addr_i[p][31])
      else begin
        note_failure($sformatf("inst_rsp_o[%0d].error", p), $sampled(inst_rsp_o[p].error),
                     $sampled(inst_addr_i[p][31]));
        $error("Fetch error flag mismatch on port %0d", p);
      end

    // Ready is a single-cycle pulse per fetch
    ready_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |=> !inst_ready_o[p])
      else begin
        note_failure($sformatf("inst_ready_o[%0d]", p), 32'd1, 32'd0);
        $error("Ready held high on port %0d", p);
      end
  end

  line_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fill_req_valid_o |-> fill_req_addr_o[icache_cfg_pkg::LINE_ALIGN-1:0] == '0)
    else begin
      note_failure("fill_req_addr_o", $sampled(fill_req_addr_o),
                   $sampled(fill_req_addr_o) & ~32'hF);
      $error("Fill address not line aligned");
    end

  valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_q |-> fill_req_valid_o)
    else begin
      note_failure("fill_req_valid_o", 32'd0, 32'd1);
      $error("Fill request dropped under back-pressure");
    end

  addr_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_q |-> fill_req_addr_o == addr_prev_q)
    else begin
      note_failure("fill_req_addr_o", $sampled(fill_req_addr_o), $sampled(addr_prev_q));
      $error("Fill address changed under back-pressure");
    end

  quiet_after_reset: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !seen_valid_q |-> !fill_req_valid_o && inst_ready_o == '0)
    else begin
      note_failure("fill_req_valid_o/inst_ready_o",
                   {$sampled(inst_ready_o), $sampled(fill_req_valid_o)}, 32'd0);
      $error("Activity before the first fetch");
    end

  // With both ports waiting, back-to-back accepted requests alternate
  round_robin: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|grant_i) && (&line_req_i) && prev_both_q |-> grant_i != prev_grant_q)
    else begin
      note_failure("grant", $sampled(grant_i),
                   icache_cfg_pkg::port_mask_t'(~$sampled(prev_grant_q)));
      $error("Same port granted twice while the other waited");
    end

endmodule

bind icache_bypass_top icache_bypass_assert u_assert (
  .clk_i            ( clk_i            ),
  .arst_n_i         ( arst_n_i         ),
  .inst_valid_i     ( inst_valid_i     ),
  .inst_addr_i      ( inst_addr_i      ),
  .inst_ready_o     ( inst_ready_o     ),
  .inst_rsp_o       ( inst_rsp_o       ),
  .fill_req_valid_o ( fill_req_valid_o ),
  .fill_req_addr_o  ( fill_req_addr_o  ),
  .fill_req_ready_i ( fill_req_ready_i ),
  .line_req_i       ( line_req         ),
  .grant_i          ( grant            )
);

`default_nettype wire

// ==== dv/tb_icache_bypass.sv ====
/*
 * Testbench for the instruction cache bypass path.
 * Two fetch ports run random fetches against an in-order fill memory model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_icache_bypass;

  localparam int unsigned CLK_PERIOD       = 20;
  localparam int unsigned RESET_CYCLES     = 16;
  localparam int unsigned FETCHES          = 40;
  localparam int unsigned CYCLES_PER_FETCH = 40;
  localparam int unsigned BUSY_CYCLES      = 12;
  localparam int unsigned NR_PORTS         = icache_cfg_pkg::NR_FETCH_PORTS;

  logic                                      clk_i            = 1'b0;
  logic                                      arst_n_i         = 1'b0;
  icache_cfg_pkg::port_mask_t                inst_valid_i     = '0;
  icache_cfg_pkg::addr_t [NR_PORTS-1:0]      inst_addr_i      = '0;
  icache_cfg_pkg::port_mask_t                inst_ready_o;
  icache_bus_pkg::fetch_rsp_t [NR_PORTS-1:0] inst_rsp_o;
  logic                                      fill_req_valid_o;
  icache_cfg_pkg::addr_t                     fill_req_addr_o;
  logic                                      fill_req_ready_i = 1'b0;
  logic                                      fill_rsp_valid_i = 1'b0;
  icache_bus_pkg::fill_rsp_t                 fill_rsp_i       = '0;

  integer                                    seed             = 31;
  icache_cfg_pkg::addr_t                     accepted [$];
  int unsigned                               rsp_wait         = 0;
  int unsigned                               busy_left        = 0;

  icache_bypass_top dut_i (.*);

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // Word k of the line at A is A + 4k with the upper half pattern applied
  function automatic icache_bus_pkg::fill_rsp_t line_for(icache_cfg_pkg::addr_t line_addr);
    icache_bus_pkg::fill_rsp_t rsp;
    for (int k = 0; k < icache_cfg_pkg::WORDS_PER_LINE; k++) begin
      rsp.data[k*32 +: 32] = icache_cfg_pkg::addr_t'(line_addr + 4 * k) ^ 32'h5A5A_0000;
    end
    rsp.error = line_addr[31];
    return rsp;
  endfunction

  // Fill memory with random back-pressure and in-order replies after 1 to 4 cycles
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      fill_req_ready_i <= 1'b0;
      fill_rsp_valid_i <= 1'b0;
    end else begin
      fill_rsp_valid_i <= 1'b0;
      if (accepted.size() != 0) begin
        if (rsp_wait == 0) rsp_wait = 1 + ($random(seed) & 3);
        rsp_wait--;
        if (rsp_wait == 0) begin
          fill_rsp_valid_i <= 1'b1;
          fill_rsp_i       <= line_for(accepted.pop_front());
        end
      end
      if (fill_req_valid_o && fill_req_ready_i) begin
        accepted.push_back(fill_req_addr_o);
        // A long busy stretch lets the granted port return while the other still waits
        if (($random(seed) & 3) == 0) busy_left = BUSY_CYCLES;
      end
      if (busy_left != 0) begin
        busy_left--;
        fill_req_ready_i <= 1'b0;
      end else begin
        fill_req_ready_i <= ($random(seed) & 3) != 0;
      end
    end
  end

  // Port p fetches from its own 16 MiB window, so accepted addresses name their port
  task automatic run_port(input int unsigned p);
    icache_cfg_pkg::addr_t addr;
    int unsigned           gap;
    for (int unsigned n = 0; n < FETCHES; n++) begin
      addr = ($random(seed) & 32'h00FF_FFFC) | (p << 24);
      if (($random(seed) & 7) == 0) addr[31] = 1'b1;
      @(posedge clk_i);
      inst_valid_i[p] <= 1'b1;
      inst_addr_i[p]  <= addr;
      do begin
        @(posedge clk_i);
      end while (!inst_ready_o[p]);
      inst_valid_i[p] <= 1'b0;
      gap = $random(seed) & 3;
      repeat (gap) @(posedge clk_i);
    end
  endtask

  task automatic print_failure();
    $display("ERROR: %s = 0x%08h, expected 0x%08h", dut_i.u_assert.fail_sig,
             dut_i.u_assert.fail_got, dut_i.u_assert.fail_exp);
    $display("TESTS FAILED");
  endtask

  initial begin : failure_watch
    wait (dut_i.u_assert.fail_cnt != 0);
    print_failure();
    $fatal(1);
  end

  initial begin : watchdog
    #((RESET_CYCLES + NR_PORTS * FETCHES * CYCLES_PER_FETCH) * CLK_PERIOD);
    $display("Fetches did not complete before the watchdog expired");
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin : main
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    fork
      run_port(0);
      run_port(1);
    join
    repeat (8) @(posedge clk_i);
    if (dut_i.u_assert.fail_cnt != 0) begin
      print_failure();
      $fatal(1);
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== icache_bypass.f ====
rtl/icache_cfg_pkg.sv
rtl/icache_bus_pkg.sv
rtl/bypass_port_ctrl.sv
rtl/fill_req_arbiter.sv
rtl/fill_rsp_router.sv
rtl/icache_bypass_top.sv
dv/icache_bypass_assert.sv
dv/tb_icache_bypass.sv
